// ==== logic/dma_pkg.sv ====
package dma_pkg;

    // ****************************************
    // bus and field widths
    // ****************************************
    localparam int tlp_data_w = 128;
    localparam int addr_w     = 64;
    localparam int len_w      = 10;
    localparam int apb_addr_w = 9;
    localparam int apb_data_w = 32;
    localparam int tag_w      = 8;

    // ****************************************
    // tlp fmt/type bytes
    // ****************************************
    localparam logic [7:0] fmt_mwr32 = 8'h40;
    localparam logic [7:0] fmt_mwr64 = 8'h60;
    localparam logic [7:0] fmt_mrd32 = 8'h00;
    localparam logic [7:0] fmt_mrd64 = 8'h20;

    // ****************************************
    // apb register map
    // ****************************************
    localparam logic [apb_addr_w-1:0] reg_addr_lo = 9'h000;
    localparam logic [apb_addr_w-1:0] reg_addr_hi = 9'h004;
    // length in dw, 0 stands for 1024
    localparam logic [apb_addr_w-1:0] reg_length  = 9'h008;
    localparam logic [apb_addr_w-1:0] reg_data    = 9'h00C;
    // bit0 write start / pending, bit1 read start / pending, bit2 flag
    localparam logic [apb_addr_w-1:0] reg_ctrl    = 9'h010;

    // misc header constants
    localparam logic [3:0] first_be   = 4'hF;
    localparam int         dw_per_4kb = 1024;

endpackage

// ==== logic/dma_controller.sv ====
`timescale 1ns/10ps

module dma_controller
    import dma_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    // apb slave
    input  logic                  i_apb_psel,
    input  logic                  i_apb_penable,
    input  logic                  i_apb_pwrite,
    input  logic [apb_addr_w-1:0] i_apb_paddr,
    input  logic [apb_data_w-1:0] i_apb_pwdata,
    input  logic [3:0]            i_apb_pstrb,
    output logic                  o_apb_prdy,
    output logic [apb_data_w-1:0] o_apb_prdata,
    // request / ack toward the generators
    output logic                  o_mwr_req,
    input  logic                  i_mwr_ack,
    output logic                  o_mrd_req,
    input  logic                  i_mrd_ack,
    output logic [addr_w-1:0]     o_req_addr,
    output logic [len_w-1:0]      o_req_length,
    output logic [31:0]           o_req_data,
    output logic                  o_cross_4kb_boundary
);

    logic [apb_data_w-1:0] addr_lo_q;
    logic [apb_data_w-1:0] addr_hi_q;
    logic [len_w-1:0]      length_q;
    logic [apb_data_w-1:0] data_q;
    logic                  wr_acc;
    logic                  start_wr;
    logic                  start_rd;
    logic [len_w:0]        eff_len;
    logic [len_w+1:0]      page_sum;

    // byte-lane merge of a write into an existing register
    function automatic logic [apb_data_w-1:0] merge_bytes(
        input logic [apb_data_w-1:0] old_v,
        input logic [apb_data_w-1:0] new_v,
        input logic [3:0]            strb
    );
        logic [apb_data_w-1:0] res;
        res = old_v;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
            begin
                res[i*8 +: 8] = new_v[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // no wait states
    assign o_apb_prdy = i_apb_psel && i_apb_penable;
    assign wr_acc     = i_apb_psel && i_apb_penable && i_apb_pwrite;
    assign start_wr   = wr_acc && (i_apb_paddr == reg_ctrl) && i_apb_pstrb[0] && i_apb_pwdata[0];
    assign start_rd   = wr_acc && (i_apb_paddr == reg_ctrl) && i_apb_pstrb[0] && i_apb_pwdata[1];

    // ****************************************
    // register file
    // ****************************************
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            addr_lo_q <= '0;
            addr_hi_q <= '0;
            length_q  <= '0;
            data_q    <= '0;
        end
        else if (wr_acc)
        begin
            case (i_apb_paddr)
                reg_addr_lo: addr_lo_q <= merge_bytes(addr_lo_q, i_apb_pwdata, i_apb_pstrb);
                reg_addr_hi: addr_hi_q <= merge_bytes(addr_hi_q, i_apb_pwdata, i_apb_pstrb);
                reg_length:  length_q  <= len_w'(merge_bytes(apb_data_w'(length_q),
                                                             i_apb_pwdata, i_apb_pstrb));
                reg_data:    data_q    <= merge_bytes(data_q, i_apb_pwdata, i_apb_pstrb);
                default:     ;
            endcase
        end
    end

    always_comb
    begin
        o_apb_prdata = '0;
        if (i_apb_psel && !i_apb_pwrite)
        begin
            case (i_apb_paddr)
                reg_addr_lo: o_apb_prdata = addr_lo_q;
                reg_addr_hi: o_apb_prdata = addr_hi_q;
                reg_length:  o_apb_prdata = apb_data_w'(length_q);
                reg_data:    o_apb_prdata = data_q;
                reg_ctrl:    o_apb_prdata = {29'd0, o_cross_4kb_boundary, o_mrd_req, o_mwr_req};
                default:     o_apb_prdata = '0;
            endcase
        end
    end

    // ****************************************
    // requests and boundary flag
    // ****************************************
    // a start while pending is dropped
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_mwr_req            <= 1'b0;
            o_mrd_req            <= 1'b0;
            o_cross_4kb_boundary <= 1'b0;
        end
        else
        begin
            if (i_mwr_ack)
                o_mwr_req <= 1'b0;
            else if (start_wr)
                o_mwr_req <= 1'b1;

            if (i_mrd_ack)
                o_mrd_req <= 1'b0;
            else if (start_rd)
                o_mrd_req <= 1'b1;

            o_cross_4kb_boundary <= (page_sum > dw_per_4kb);
        end
    end

    assign eff_len  = (length_q == '0) ? (len_w+1)'(dw_per_4kb) : {1'b0, length_q};
    assign page_sum = {2'b00, addr_lo_q[11:2]} + {1'b0, eff_len};

    assign o_req_addr   = {addr_hi_q, addr_lo_q};
    assign o_req_length = length_q;
    assign o_req_data   = data_q;

    // requests only drop after the generator has taken them
    a_mwr_req_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        $fell(o_mwr_req) |-> $past(i_mwr_ack));
    a_mrd_req_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        $fell(o_mrd_req) |-> $past(i_mrd_ack));

endmodule

// ==== logic/mwr_tlp_gen.sv ====
`timescale 1ns/10ps

module mwr_tlp_gen
    import dma_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_mwr_req,
    input  logic [addr_w-1:0]     i_req_addr,
    input  logic [31:0]           i_req_data,
    input  logic [7:0]            i_cfg_pbus_num,
    input  logic [4:0]            i_cfg_pbus_dev_num,
    input  logic                  i_trdy,
    output logic                  o_mwr_ack,
    output logic                  o_tvld,
    output logic [tlp_data_w-1:0] o_tdata,
    output logic                  o_tlast
);

    logic                  is_64;
    logic [31:0]           dw0;
    logic [31:0]           dw1;
    logic [31:0]           addr_lo;
    logic [tlp_data_w-1:0] first_beat;
    logic [31:0]           second_q;
    logic                  second_pend;
    logic                  gen_empty;
    logic                  beat_xfer;

    // 64-bit format only when the upper address is in use
    assign is_64   = |i_req_addr[addr_w-1:32];
    assign addr_lo = {i_req_addr[31:2], 2'b00};

    // one dw payload, tag 0, last be 0
    assign dw0 = {(is_64 ? fmt_mwr64 : fmt_mwr32), 14'd0, len_w'(1)};
    assign dw1 = {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000, tag_w'(0), 4'h0, first_be};

    assign first_beat = is_64 ? {addr_lo, i_req_addr[addr_w-1:32], dw1, dw0}
                              : {i_req_data, addr_lo, dw1, dw0};

    assign gen_empty = !o_tvld && !second_pend;
    assign beat_xfer = o_tvld && i_trdy;

    // ****************************************
    // ack and beat sequencing
    // ****************************************
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_mwr_ack   <= 1'b0;
            o_tvld      <= 1'b0;
            o_tlast     <= 1'b0;
            second_pend <= 1'b0;
        end
        else
        begin
            o_mwr_ack <= i_mwr_req && gen_empty && !o_mwr_ack;
            if (o_mwr_ack)
            begin
                o_tvld      <= 1'b1;
                o_tlast     <= !is_64;
                second_pend <= is_64;
            end
            else if (beat_xfer)
            begin
                if (second_pend)
                begin
                    // move on to the data beat of a 64-bit write
                    o_tlast     <= 1'b1;
                    second_pend <= 1'b0;
                end
                else
                begin
                    o_tvld <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_mwr_ack)
        begin
            o_tdata  <= first_beat;
            second_q <= i_req_data;
        end
        else if (beat_xfer && second_pend)
        begin
            o_tdata <= {(tlp_data_w-32)'(0), second_q};
        end
    end

    a_tdata_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_tvld && !i_trdy |=> $stable(o_tdata));

endmodule

// ==== logic/mrd_tlp_gen.sv ====
`timescale 1ns/10ps

module mrd_tlp_gen
    import dma_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_mrd_req,
    input  logic [addr_w-1:0]     i_req_addr,
    input  logic [len_w-1:0]      i_req_length,
    input  logic [7:0]            i_cfg_pbus_num,
    input  logic [4:0]            i_cfg_pbus_dev_num,
    input  logic                  i_trdy,
    output logic                  o_mrd_ack,
    output logic                  o_tvld,
    output logic [tlp_data_w-1:0] o_tdata,
    output logic                  o_tlast
);

    logic                  is_64;
    logic [3:0]            last_be;
    logic [31:0]           dw0;
    logic [31:0]           dw1;
    logic [31:0]           addr_lo;
    logic [tlp_data_w-1:0] hdr_beat;
    logic [tag_w-1:0]      tag_q;

    assign is_64   = |i_req_addr[addr_w-1:32];
    assign addr_lo = {i_req_addr[31:2], 2'b00};
    // single dw read has no last be
    assign last_be = (i_req_length == len_w'(1)) ? 4'h0 : 4'hF;

    assign dw0 = {(is_64 ? fmt_mrd64 : fmt_mrd32), 14'd0, i_req_length};
    assign dw1 = {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000, tag_q, last_be, first_be};

    assign hdr_beat = is_64 ? {addr_lo, i_req_addr[addr_w-1:32], dw1, dw0}
                            : {32'd0, addr_lo, dw1, dw0};

    // every read is a single beat
    assign o_tlast = 1'b1;

    // ****************************************
    // ack, holding register and tag
    // ****************************************
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_mrd_ack <= 1'b0;
            o_tvld    <= 1'b0;
            tag_q     <= '0;
        end
        else
        begin
            o_mrd_ack <= i_mrd_req && !o_tvld && !o_mrd_ack;
            if (o_mrd_ack)
            begin
                o_tvld <= 1'b1;
                // wraps after 255
                tag_q  <= tag_q + 1'b1;
            end
            else if (i_trdy)
            begin
                o_tvld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_mrd_ack)
            o_tdata <= hdr_beat;
    end

    a_ack_on_req: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_mrd_ack |-> i_mrd_req);

endmodule

// ==== logic/tlp_tx_mux.sv ====
`timescale 1ns/10ps

module tlp_tx_mux
    import dma_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    // write request stream
    input  logic                  i_mwr_tvld,
    input  logic [tlp_data_w-1:0] i_mwr_tdata,
    input  logic                  i_mwr_tlast,
    output logic                  o_mwr_trdy,
    // read request stream
    input  logic                  i_mrd_tvld,
    input  logic [tlp_data_w-1:0] i_mrd_tdata,
    input  logic                  i_mrd_tlast,
    output logic                  o_mrd_trdy,
    // slave port toward the pcie core
    input  logic                  i_axis_slave_trdy,
    output logic                  o_axis_slave_tvld,
    output logic [tlp_data_w-1:0] o_axis_slave_tdata,
    output logic                  o_axis_slave_tlast
);

    logic busy_q;
    logic sel_q;
    logic cur_sel;

    // 0 selects write, 1 selects read; write wins at a packet start
    assign cur_sel = busy_q ? sel_q : (!i_mwr_tvld && i_mrd_tvld);

    assign o_axis_slave_tvld  = cur_sel ? i_mrd_tvld  : i_mwr_tvld;
    assign o_axis_slave_tdata = cur_sel ? i_mrd_tdata : i_mwr_tdata;
    assign o_axis_slave_tlast = cur_sel ? i_mrd_tlast : i_mwr_tlast;

    assign o_mwr_trdy = !cur_sel && i_axis_slave_trdy;
    assign o_mrd_trdy = cur_sel && i_axis_slave_trdy;

    // ****************************************
    // grant lock
    // ****************************************
    // held from the first presented beat until tlast goes through
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            busy_q <= 1'b0;
            sel_q  <= 1'b0;
        end
        else if (o_axis_slave_tvld)
        begin
            busy_q <= !(i_axis_slave_trdy && o_axis_slave_tlast);
            sel_q  <= cur_sel;
        end
    end

    a_grant_lock: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_axis_slave_tvld && !(i_axis_slave_trdy && o_axis_slave_tlast)
        |=> cur_sel == $past(cur_sel));

endmodule

// ==== logic/pcie_dma_top.sv ====
`timescale 1ns/10ps

module pcie_dma_top
    import dma_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    // apb
    input  logic                  i_apb_psel,
    input  logic                  i_apb_penable,
    input  logic                  i_apb_pwrite,
    input  logic [apb_addr_w-1:0] i_apb_paddr,
    input  logic [apb_data_w-1:0] i_apb_pwdata,
    input  logic [3:0]            i_apb_pstrb,
    output logic                  o_apb_prdy,
    output logic [apb_data_w-1:0] o_apb_prdata,
    // requester id
    input  logic [7:0]            i_cfg_pbus_num,
    input  logic [4:0]            i_cfg_pbus_dev_num,
    // axis slave
    input  logic                  i_axis_slave_trdy,
    output logic                  o_axis_slave_tvld,
    output logic [tlp_data_w-1:0] o_axis_slave_tdata,
    output logic                  o_axis_slave_tlast,
    output logic                  o_cross_4kb_boundary
);

    // ****************************************
    // controller to generators
    // ****************************************
    logic              mwr_req;
    logic              mwr_ack;
    logic              mrd_req;
    logic              mrd_ack;
    logic [addr_w-1:0] req_addr;
    logic [len_w-1:0]  req_length;
    logic [31:0]       req_data;

    // generator streams
    logic                  mwr_tvld;
    logic                  mwr_trdy;
    logic [tlp_data_w-1:0] mwr_tdata;
    logic                  mwr_tlast;
    logic                  mrd_tvld;
    logic                  mrd_trdy;
    logic [tlp_data_w-1:0] mrd_tdata;
    logic                  mrd_tlast;

    dma_controller u_dma_controller (
        .clk                  (clk),
        .i_arst_n             (i_arst_n),
        .i_apb_psel           (i_apb_psel),
        .i_apb_penable        (i_apb_penable),
        .i_apb_pwrite         (i_apb_pwrite),
        .i_apb_paddr          (i_apb_paddr),
        .i_apb_pwdata         (i_apb_pwdata),
        .i_apb_pstrb          (i_apb_pstrb),
        .o_apb_prdy           (o_apb_prdy),
        .o_apb_prdata         (o_apb_prdata),
        .o_mwr_req            (mwr_req),
        .i_mwr_ack            (mwr_ack),
        .o_mrd_req            (mrd_req),
        .i_mrd_ack            (mrd_ack),
        .o_req_addr           (req_addr),
        .o_req_length         (req_length),
        .o_req_data           (req_data),
        .o_cross_4kb_boundary (o_cross_4kb_boundary)
    );

    mwr_tlp_gen u_mwr_tlp_gen (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_mwr_req          (mwr_req),
        .i_req_addr         (req_addr),
        .i_req_data         (req_data),
        .i_cfg_pbus_num     (i_cfg_pbus_num),
        .i_cfg_pbus_dev_num (i_cfg_pbus_dev_num),
        .i_trdy             (mwr_trdy),
        .o_mwr_ack          (mwr_ack),
        .o_tvld             (mwr_tvld),
        .o_tdata            (mwr_tdata),
        .o_tlast            (mwr_tlast)
    );

    mrd_tlp_gen u_mrd_tlp_gen (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_mrd_req          (mrd_req),
        .i_req_addr         (req_addr),
        .i_req_length       (req_length),
        .i_cfg_pbus_num     (i_cfg_pbus_num),
        .i_cfg_pbus_dev_num (i_cfg_pbus_dev_num),
        .i_trdy             (mrd_trdy),
        .o_mrd_ack          (mrd_ack),
        .o_tvld             (mrd_tvld),
        .o_tdata            (mrd_tdata),
        .o_tlast            (mrd_tlast)
    );

    // both request streams onto the single slave port
    tlp_tx_mux u_tlp_tx_mux (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_mwr_tvld         (mwr_tvld),
        .i_mwr_tdata        (mwr_tdata),
        .i_mwr_tlast        (mwr_tlast),
        .o_mwr_trdy         (mwr_trdy),
        .i_mrd_tvld         (mrd_tvld),
        .i_mrd_tdata        (mrd_tdata),
        .i_mrd_tlast        (mrd_tlast),
        .o_mrd_trdy         (mrd_trdy),
        .i_axis_slave_trdy  (i_axis_slave_trdy),
        .o_axis_slave_tvld  (o_axis_slave_tvld),
        .o_axis_slave_tdata (o_axis_slave_tdata),
        .o_axis_slave_tlast (o_axis_slave_tlast)
    );

endmodule

// ==== sim/tb_pcie_dma.sv ====
`timescale 1ns/10ps

module tb_pcie_dma
    import dma_pkg::*;
();

    // start holds the ctrl write value (1 write, 2 read, 3 both)
    typedef struct packed {
        logic [1:0]  start;
        logic [63:0] addr;
        logic [9:0]  length;
        logic [31:0] data;
        logic        stall;
        logic        flag;
    } test_t;

    logic          clk;
    logic          arst_n;
    logic          apb_psel;
    logic          apb_penable;
    logic          apb_pwrite;
    logic [8:0]    apb_paddr;
    logic [31:0]   apb_pwdata;
    logic [3:0]    apb_pstrb;
    logic          apb_prdy;
    logic [31:0]   apb_prdata;
    logic [7:0]    cfg_bus;
    logic [4:0]    cfg_dev;
    logic          trdy;
    logic          tvld;
    logic [127:0]  tdata;
    logic          tlast;
    logic          flag;

    test_t         tests [10];
    logic          stall_mode;
    logic [7:0]    exp_tag;
    int            errors;
    logic [127:0]  exp_data [$];
    logic          exp_last [$];
    logic [127:0]  got_data [$];
    logic          got_last [$];
    logic          hold_pending;
    logic [127:0]  held_data;
    logic          held_last;

    pcie_dma_top dut0 (
        .clk                  (clk),
        .i_arst_n             (arst_n),
        .i_apb_psel           (apb_psel),
        .i_apb_penable        (apb_penable),
        .i_apb_pwrite         (apb_pwrite),
        .i_apb_paddr          (apb_paddr),
        .i_apb_pwdata         (apb_pwdata),
        .i_apb_pstrb          (apb_pstrb),
        .o_apb_prdy           (apb_prdy),
        .o_apb_prdata         (apb_prdata),
        .i_cfg_pbus_num       (cfg_bus),
        .i_cfg_pbus_dev_num   (cfg_dev),
        .i_axis_slave_trdy    (trdy),
        .o_axis_slave_tvld    (tvld),
        .o_axis_slave_tdata   (tdata),
        .o_axis_slave_tlast   (tlast),
        .o_cross_4kb_boundary (flag)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ****************************************
    // apb accesses with no wait states
    // ****************************************
    task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        @(posedge clk);
        apb_psel    <= 1'b1;
        apb_penable <= 1'b0;
        apb_pwrite  <= 1'b1;
        apb_paddr   <= addr;
        apb_pwdata  <= data;
        apb_pstrb   <= strb;
        @(posedge clk);
        apb_penable <= 1'b1;
        @(negedge clk);
        check_value("o_apb_prdy", 128'(apb_prdy), 128'(1'b1));
        @(posedge clk);
        apb_psel    <= 1'b0;
        apb_penable <= 1'b0;
        apb_pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        apb_psel    <= 1'b1;
        apb_penable <= 1'b0;
        apb_pwrite  <= 1'b0;
        apb_paddr   <= addr;
        @(posedge clk);
        apb_penable <= 1'b1;
        @(negedge clk);
        check_value("o_apb_prdy", 128'(apb_prdy), 128'(1'b1));
        data = apb_prdata;
        @(posedge clk);
        apb_psel    <= 1'b0;
        apb_penable <= 1'b0;
    endtask

    // ****************************************
    // expected tlp beats
    // ****************************************
    task automatic add_write_beats(input logic [63:0] addr, input logic [31:0] data);
        logic [31:0] dw0;
        logic [31:0] dw1;
        logic [31:0] alo;
        alo = {addr[31:2], 2'b00};
        dw1 = {cfg_bus, cfg_dev, 3'b000, 8'h00, 4'h0, 4'hF};
        if (addr[63:32] == 32'd0)
        begin
            dw0 = {8'h40, 14'd0, 10'd1};
            exp_data.push_back({data, alo, dw1, dw0});
            exp_last.push_back(1'b1);
        end
        else
        begin
            // header beat then data beat
            dw0 = {8'h60, 14'd0, 10'd1};
            exp_data.push_back({alo, addr[63:32], dw1, dw0});
            exp_last.push_back(1'b0);
            exp_data.push_back({96'd0, data});
            exp_last.push_back(1'b1);
        end
    endtask

    task automatic add_read_beat(input logic [63:0] addr, input logic [9:0] length,
                                 input logic [7:0] tag);
        logic [31:0] dw0;
        logic [31:0] dw1;
        logic [31:0] alo;
        logic [3:0]  lbe;
        alo = {addr[31:2], 2'b00};
        lbe = (length == 10'd1) ? 4'h0 : 4'hF;
        dw1 = {cfg_bus, cfg_dev, 3'b000, tag, lbe, 4'hF};
        if (addr[63:32] == 32'd0)
        begin
            dw0 = {8'h00, 14'd0, length};
            exp_data.push_back({32'd0, alo, dw1, dw0});
        end
        else
        begin
            dw0 = {8'h20, 14'd0, length};
            exp_data.push_back({alo, addr[63:32], dw1, dw0});
        end
        exp_last.push_back(1'b1);
    endtask

    task automatic load_tests();
        tests[0] = '{2'd1, 64'h0000_0000_1000_0010, 10'd1,    32'hDEAD_BEEF, 1'b0, 1'b0};
        tests[1] = '{2'd1, 64'h0000_0001_2345_6788, 10'd4,    32'hCAFE_F00D, 1'b0, 1'b0};
        tests[2] = '{2'd2, 64'h0000_0000_8000_0FF8, 10'd1,    32'h0000_0000, 1'b0, 1'b0};
        tests[3] = '{2'd2, 64'h0000_0000_8000_0FF8, 10'd3,    32'h0000_0000, 1'b0, 1'b1};
        tests[4] = '{2'd2, 64'h0000_00AB_0000_0000, 10'd0,    32'h0000_0000, 1'b0, 1'b0};
        tests[5] = '{2'd2, 64'h0000_00AB_0000_0004, 10'd0,    32'h0000_0000, 1'b0, 1'b1};
        tests[6] = '{2'd3, 64'h0000_0002_0000_0100, 10'd16,   32'h0123_4567, 1'b1, 1'b0};
        tests[7] = '{2'd3, 64'h0000_0000_0000_3FFC, 10'd2,    32'h89AB_CDEF, 1'b1, 1'b1};
        tests[8] = '{2'd1, 64'hFFFF_FFFF_FFFF_FFF0, 10'd8,    32'h55AA_55AA, 1'b1, 1'b1};
        tests[9] = '{2'd2, 64'h0000_0000_0000_0003, 10'd1023, 32'h0000_0000, 1'b1, 1'b0};
    endtask

    task automatic run_test(input int t);
        test_t       tc;
        logic [31:0] rd;
        int          cycles;
        int          err_start;
        tc = tests[t];
        err_start = errors;
        stall_mode <= tc.stall;
        exp_data.delete();
        exp_last.delete();
        got_data.delete();
        got_last.delete();

        apb_write(reg_addr_lo, tc.addr[31:0], 4'hF);
        apb_write(reg_addr_hi, tc.addr[63:32], 4'hF);
        apb_write(reg_length, {22'd0, tc.length}, 4'hF);
        // upper lanes from a full write, lower lanes from a strobed one
        apb_write(reg_data, {tc.data[31:16], ~tc.data[15:0]}, 4'hF);
        apb_write(reg_data, {~tc.data[31:16], tc.data[15:0]}, 4'b0011);
        apb_read(reg_addr_lo, rd);
        check_value("reg_addr_lo", 128'(rd), 128'(tc.addr[31:0]));
        apb_read(reg_addr_hi, rd);
        check_value("reg_addr_hi", 128'(rd), 128'(tc.addr[63:32]));
        apb_read(reg_length, rd);
        check_value("reg_length", 128'(rd), 128'({22'd0, tc.length}));
        apb_read(reg_data, rd);
        check_value("reg_data", 128'(rd), 128'(tc.data));
        @(negedge clk);
        check_value("o_cross_4kb_boundary", 128'(flag), 128'(tc.flag));

        // write wins when both start together
        if (tc.start[0])
            add_write_beats(tc.addr, tc.data);
        if (tc.start[1])
        begin
            add_read_beat(tc.addr, tc.length, exp_tag);
            exp_tag = exp_tag + 8'd1;
        end
        apb_write(reg_ctrl, {30'd0, tc.start}, 4'hF);

        cycles = 0;
        while (got_data.size() < exp_data.size() && cycles < 100)
        begin
            @(posedge clk);
            cycles++;
        end
        // room for any stray extra beat
        repeat (4) @(posedge clk);
        if (got_data.size() != exp_data.size())
        begin
            $display("test %0d expected %0d beats on the slave port but saw %0d",
                     t, exp_data.size(), got_data.size());
            errors++;
        end
        else
        begin
            for (int i = 0; i < exp_data.size(); i++)
            begin
                check_value("o_axis_slave_tdata", got_data[i], exp_data[i]);
                check_value("o_axis_slave_tlast", 128'(got_last[i]), 128'(exp_last[i]));
            end
        end
        apb_read(reg_ctrl, rd);
        check_value("reg_ctrl", 128'(rd), 128'({29'd0, tc.flag, 2'b00}));
        stall_mode <= 1'b0;

        if (errors == err_start)
            $display("test %0d start %0d beats %0d ok", t, tc.start, exp_data.size());
        else
            $display("test %0d start %0d had %0d errors", t, tc.start, errors - err_start);
    endtask

    // ****************************************
    // slave port sink and capture
    // ****************************************
    always @(posedge clk)
    begin
        if (stall_mode)
            trdy <= ($urandom % 3) != 0;
        else
            trdy <= 1'b1;
    end

    // sampled mid-cycle where port values have settled
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (hold_pending)
            begin
                check_value("o_axis_slave_tvld", 128'(tvld), 128'(1'b1));
                check_value("o_axis_slave_tdata", tdata, held_data);
                check_value("o_axis_slave_tlast", 128'(tlast), 128'(held_last));
            end
            hold_pending = tvld && !trdy;
            held_data    = tdata;
            held_last    = tlast;
            if (tvld && trdy)
            begin
                got_data.push_back(tdata);
                got_last.push_back(tlast);
            end
        end
    end

    initial
    begin
        repeat ($size(tests) * 200) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        void'($urandom(42309));
        arst_n       = 1'b0;
        apb_psel     = 1'b0;
        apb_penable  = 1'b0;
        apb_pwrite   = 1'b0;
        apb_paddr    = '0;
        apb_pwdata   = '0;
        apb_pstrb    = 4'hF;
        cfg_bus      = 8'hA5;
        cfg_dev      = 5'h0B;
        trdy         = 1'b0;
        stall_mode   = 1'b0;
        exp_tag      = 8'd0;
        errors       = 0;
        hold_pending = 1'b0;
        held_data    = '0;
        held_last    = 1'b0;
        load_tests();

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("o_axis_slave_tvld", 128'(tvld), 128'(1'b0));
        check_value("o_cross_4kb_boundary", 128'(flag), 128'(1'b0));

        for (int t = 0; t < $size(tests); t++)
        begin
            run_test(t);
        end

        $display("%0d tests run, %0d checks failed", $size(tests), errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== build.f ====
logic/dma_pkg.sv
logic/dma_controller.sv
logic/mwr_tlp_gen.sv
logic/mrd_tlp_gen.sv
logic/tlp_tx_mux.sv
logic/pcie_dma_top.sv
sim/tb_pcie_dma.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pcie dma testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_pcie_dma -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_pcie_dma)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
